// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = issue_tb
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: all.f
hdl/ooo_pkg.sv
hdl/rs_if.sv
hdl/reservation_station.sv
hdl/issue_selector.sv
hdl/issue_logic.sv
hdl/issue_top.sv
tests/issue_asserts.sv
tests/issue_tb.sv

// File: hdl/issue_logic.sv
`timescale 1ns/1ps

module issue_logic import ooo_pkg::*; (
    input  logic           clk,
    input  logic           reset,

    rs_if.iss              rs,

    // fu ready levels
    input  logic           alu_ready_i,
    input  logic           mul_ready_i,
    input  logic           load_ready_i,
    input  logic           br_ready_i,

    // registered fu requests, valid is a single-cycle pulse
    output issue_packet_t  alu_req_o,
    output issue_packet_t  mul_req_o,
    output issue_packet_t  load_req_o,
    output issue_packet_t  br_req_o
);

    logic          [FU_NUM-1:0]   fu_ready;
    logic          [RS_DEPTH-1:0] grant;
    issue_packet_t                slot_pkt  [ISSUE_WIDTH];  // granted ops in index order
    issue_packet_t                req_d     [FU_NUM];       // routed by fu type
    issue_packet_t                req_pkt_q [FU_NUM];       // request payload
    logic          [FU_NUM-1:0]   req_vld_q;                // request valid pulses

    // strip the ready bits, carry the tags through
    function automatic issue_packet_t to_packet(input rs_entry_t e);
        issue_packet_t p;
        p.valid    = 1'b1;
        p.fu_type  = e.fu_type;
        p.opcode   = e.opcode;
        p.rob_idx  = e.rob_idx;
        p.dest_tag = e.dest_tag;
        p.src1_tag = e.src1_tag;
        p.src2_tag = e.src2_tag;
        p.imm      = e.imm;
        return p;
    endfunction

    // ============================================================
    // selection
    // ============================================================
    assign fu_ready[FU_ALU]    = alu_ready_i;
    assign fu_ready[FU_MUL]    = mul_ready_i;
    assign fu_ready[FU_LOAD]   = load_ready_i;
    assign fu_ready[FU_BRANCH] = br_ready_i;

    issue_selector i_sel (
        .ready_i    (rs.ready),
        .entries_i  (rs.entries),
        .fu_ready_i (fu_ready),
        .grant_o    (grant)
    );

    assign rs.grant = grant;  // station frees these at this edge

    // ============================================================
    // packing and routing
    // ============================================================
    always_comb begin
        int unsigned slot;
        slot = 0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            slot_pkt[s] = '0;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (grant[i] && (slot < ISSUE_WIDTH)) begin
                slot_pkt[slot] = to_packet(rs.entries[i]);
                slot           = slot + 1;
            end
        end
    end

    // selector never gives one type two slots, so no collision here
    always_comb begin
        for (int f = 0; f < FU_NUM; f++) begin
            req_d[f] = '0;
        end
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (slot_pkt[s].valid) begin
                req_d[slot_pkt[s].fu_type] = slot_pkt[s];
            end
        end
    end

    // ============================================================
    // request registers
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_vld_q <= '0;
        end else begin
            for (int f = 0; f < FU_NUM; f++) begin
                req_vld_q[f] <= req_d[f].valid;  // drops back when nothing routed
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int f = 0; f < FU_NUM; f++) begin
            if (req_d[f].valid) begin
                req_pkt_q[f] <= req_d[f];
            end
        end
    end

    always_comb begin
        alu_req_o        = req_pkt_q[FU_ALU];
        alu_req_o.valid  = req_vld_q[FU_ALU];
        mul_req_o        = req_pkt_q[FU_MUL];
        mul_req_o.valid  = req_vld_q[FU_MUL];
        load_req_o       = req_pkt_q[FU_LOAD];
        load_req_o.valid = req_vld_q[FU_LOAD];
        br_req_o         = req_pkt_q[FU_BRANCH];
        br_req_o.valid   = req_vld_q[FU_BRANCH];
    end

endmodule

// File: hdl/issue_selector.sv
`timescale 1ns/1ps

// pure combinational pick of up to ISSUE_WIDTH ready slots
// lowest index wins, one grant per fu type per cycle
module issue_selector import ooo_pkg::*; (
    input  logic      [RS_DEPTH-1:0] ready_i,     // from station
    input  rs_entry_t [RS_DEPTH-1:0] entries_i,   // fu type lookup
    input  logic      [FU_NUM-1:0]   fu_ready_i,  // indexed by fu_type_e
    output logic      [RS_DEPTH-1:0] grant_o
);

    // ============================================================
    // priority scan
    // ============================================================
    always_comb begin
        int unsigned      n_grant;   // grants handed out so far
        logic [FU_NUM-1:0] fu_used;  // types already taken this cycle
        fu_type_e         ft;

        n_grant = 0;
        fu_used = '0;
        grant_o = '0;

        for (int i = 0; i < RS_DEPTH; i++) begin
            ft = entries_i[i].fu_type;
            if (ready_i[i] &&
                fu_ready_i[ft] &&          // unit accepts this cycle
                !fu_used[ft] &&            // single unit per type
                (n_grant < ISSUE_WIDTH)) begin
                grant_o[i]  = 1'b1;
                fu_used[ft] = 1'b1;
                n_grant     = n_grant + 1;
            end
        end
    end

endmodule

// File: hdl/issue_top.sv
`timescale 1ns/1ps

module issue_top import ooo_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,

    // dispatch
    input  logic                            dispatch_valid_i,
    input  rs_entry_t                       dispatch_entry_i,
    output logic                            rs_full_o,     // hold off dispatch

    // cdb
    input  logic [CDB_WIDTH-1:0]            cdb_valid_i,
    input  logic [CDB_WIDTH-1:0][TAG_W-1:0] cdb_tag_i,

    // fu ready levels
    input  logic                            alu_ready_i,
    input  logic                            mul_ready_i,
    input  logic                            load_ready_i,
    input  logic                            br_ready_i,

    // fu requests
    output issue_packet_t                   alu_req_o,
    output issue_packet_t                   mul_req_o,
    output issue_packet_t                   load_req_o,
    output issue_packet_t                   br_req_o
);

    // ============================================================
    // station <-> issue
    // ============================================================
    rs_if rs_bus ();

    reservation_station i_rs (
        .clk              (clk),
        .reset            (reset),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_entry_i (dispatch_entry_i),
        .rs_full_o        (rs_full_o),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_tag_i        (cdb_tag_i),
        .rs               (rs_bus)
    );

    issue_logic i_issue (
        .clk          (clk),
        .reset        (reset),
        .rs           (rs_bus),
        .alu_ready_i  (alu_ready_i),
        .mul_ready_i  (mul_ready_i),
        .load_ready_i (load_ready_i),
        .br_ready_i   (br_ready_i),
        .alu_req_o    (alu_req_o),
        .mul_req_o    (mul_req_o),
        .load_req_o   (load_req_o),
        .br_req_o     (br_req_o)
    );

endmodule

// File: hdl/ooo_pkg.sv
package ooo_pkg;

    // ============================================================
    // sizes
    // ============================================================
    localparam int unsigned RS_DEPTH    = 8;   // station entries
    localparam int unsigned ISSUE_WIDTH = 2;   // max grants per cycle
    localparam int unsigned CDB_WIDTH   = 2;   // wakeup lanes per cycle
    localparam int unsigned FU_NUM      = 4;   // one unit per fu type

    localparam int unsigned PHYS_REGS   = 64;
    localparam int unsigned TAG_W       = $clog2(PHYS_REGS);  // 6
    localparam int unsigned ROB_DEPTH   = 32;
    localparam int unsigned ROB_W       = $clog2(ROB_DEPTH);  // 5
    localparam int unsigned IMM_W       = 32;

    // ============================================================
    // encodings
    // ============================================================
    // fu type doubles as index into the per-unit ready/request arrays
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MUL    = 2'd1,
        FU_LOAD   = 2'd2,
        FU_BRANCH = 2'd3
    } fu_type_e;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_MUL  = 3'd4,
        OP_MULH = 3'd5,  // upper half of product
        OP_LOAD = 3'd6,
        OP_BEQ  = 3'd7
    } opcode_e;

    // ============================================================
    // structs
    // ============================================================
    // one station slot, src ready bits set by rename or by cdb wakeup
    typedef struct packed {
        logic               valid;
        fu_type_e           fu_type;
        opcode_e            opcode;
        logic [ROB_W-1:0]   rob_idx;
        logic [TAG_W-1:0]   dest_tag;
        logic [TAG_W-1:0]   src1_tag;
        logic               src1_rdy;
        logic [TAG_W-1:0]   src2_tag;
        logic               src2_rdy;
        logic [IMM_W-1:0]   imm;
    } rs_entry_t;

    // what the fu sees, tags only since no register values here
    typedef struct packed {
        logic               valid;     // one-cycle pulse per op
        fu_type_e           fu_type;
        opcode_e            opcode;
        logic [ROB_W-1:0]   rob_idx;
        logic [TAG_W-1:0]   dest_tag;
        logic [TAG_W-1:0]   src1_tag;
        logic [TAG_W-1:0]   src2_tag;
        logic [IMM_W-1:0]   imm;
    } issue_packet_t;

endpackage

// File: hdl/reservation_station.sv
`timescale 1ns/1ps

module reservation_station import ooo_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,

    // dispatch, one strobe per cycle at most
    input  logic                                dispatch_valid_i,
    input  rs_entry_t                           dispatch_entry_i,
    output logic                                rs_full_o,

    // result bus broadcasts
    input  logic [CDB_WIDTH-1:0]                cdb_valid_i,
    input  logic [CDB_WIDTH-1:0][TAG_W-1:0]     cdb_tag_i,

    rs_if.rs                                    rs
);

    logic      [RS_DEPTH-1:0] valid_q;     // slot occupied
    logic      [RS_DEPTH-1:0] valid_d;
    rs_entry_t [RS_DEPTH-1:0] entry_q;     // slot payload and src ready bits
    logic      [RS_DEPTH-1:0] alloc_oh;    // slot written this edge
    logic      [RS_DEPTH-1:0] wake1;       // src1 tag seen on cdb
    logic      [RS_DEPTH-1:0] wake2;       // src2 tag seen on cdb
    rs_entry_t                disp_entry;  // incoming entry after bypass

    // true if any valid cdb lane carries this tag
    function automatic logic cdb_hit(
        input logic [TAG_W-1:0]             tag,
        input logic [CDB_WIDTH-1:0]         lane_valid,
        input logic [CDB_WIDTH-1:0][TAG_W-1:0] lane_tag
    );
        logic hit;
        hit = 1'b0;
        for (int c = 0; c < CDB_WIDTH; c++) begin
            if (lane_valid[c] && (lane_tag[c] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ============================================================
    // allocation
    // ============================================================
    assign rs_full_o = &valid_q;  // straight from the flops

    // lowest free slot, one-hot, zero when full or no strobe
    always_comb begin
        logic found;
        found    = 1'b0;
        alloc_oh = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!valid_q[i] && !found) begin
                alloc_oh[i] = dispatch_valid_i;
                found       = 1'b1;
            end
        end
    end

    // same-cycle broadcast marks the incoming source ready
    always_comb begin
        disp_entry          = dispatch_entry_i;
        disp_entry.valid    = 1'b1;
        disp_entry.src1_rdy = dispatch_entry_i.src1_rdy |
                              cdb_hit(dispatch_entry_i.src1_tag, cdb_valid_i, cdb_tag_i);
        disp_entry.src2_rdy = dispatch_entry_i.src2_rdy |
                              cdb_hit(dispatch_entry_i.src2_tag, cdb_valid_i, cdb_tag_i);
    end

    // ============================================================
    // wakeup and release
    // ============================================================
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            wake1[i] = cdb_hit(entry_q[i].src1_tag, cdb_valid_i, cdb_tag_i);
            wake2[i] = cdb_hit(entry_q[i].src2_tag, cdb_valid_i, cdb_tag_i);
        end
    end

    // granted slots drop out, alloc only ever hits a free slot
    assign valid_d = (valid_q & ~rs.grant) | alloc_oh;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (alloc_oh[i]) begin
                entry_q[i] <= disp_entry;
            end else if (valid_q[i]) begin
                entry_q[i].src1_rdy <= entry_q[i].src1_rdy | wake1[i];  // sticky
                entry_q[i].src2_rdy <= entry_q[i].src2_rdy | wake2[i];
            end
        end
    end

    // ============================================================
    // outputs to issue
    // ============================================================
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            rs.entries[i]       = entry_q[i];
            rs.entries[i].valid = valid_q[i];  // live bit, not the stored copy
            rs.ready[i]         = valid_q[i] & entry_q[i].src1_rdy & entry_q[i].src2_rdy;
        end
    end

endmodule

// File: hdl/rs_if.sv
`timescale 1ns/1ps

// station <-> issue logic
// entries and ready flow out of the station, grant comes back the same cycle
interface rs_if import ooo_pkg::*; ();

    rs_entry_t [RS_DEPTH-1:0] entries;  // slot contents, valid bit is live
    logic      [RS_DEPTH-1:0] ready;    // valid & src1_rdy & src2_rdy
    logic      [RS_DEPTH-1:0] grant;    // at most ISSUE_WIDTH bits set

    // station side
    modport rs (
        output entries,
        output ready,
        input  grant
    );

    // issue side
    modport iss (
        input  entries,
        input  ready,
        output grant
    );

endinterface

// File: tests/issue_asserts.sv
`timescale 1ns/1ps

// port-level protocol and latency checks, bound into issue_top
module issue_asserts import ooo_pkg::*; (
    input logic          clk,
    input logic          reset,
    input logic          dispatch_valid_i,
    input rs_entry_t     dispatch_entry_i,
    input logic          rs_full_o,
    input logic          alu_ready_i,
    input logic          mul_ready_i,
    input logic          load_ready_i,
    input logic          br_ready_i,
    input issue_packet_t alu_req_o,
    input issue_packet_t mul_req_o,
    input issue_packet_t load_req_o,
    input issue_packet_t br_req_o
);

    logic          [FU_NUM-1:0] fu_rdy;      // indexed by fu_type_e
    logic          [FU_NUM-1:0] req_vld;
    issue_packet_t              req [FU_NUM];
    int unsigned                live_cnt;    // dispatched, not yet seen on a port
    logic                       seen_disp;
    logic                       arm1;        // fast-path op sitting in the station
    logic                       arm2;        // ...and granted, packet due now
    rs_entry_t                  ent1;
    rs_entry_t                  ent2;
    bit                         fail_quiet;
    bit                         fail_ready;
    bit                         fail_fast;
    logic                       any_fail;

    function automatic logic packet_ok(input issue_packet_t p, input rs_entry_t e);
        return p.valid && (p.fu_type == e.fu_type) && (p.opcode == e.opcode) &&
               (p.rob_idx == e.rob_idx) && (p.dest_tag == e.dest_tag) &&
               (p.src1_tag == e.src1_tag) && (p.src2_tag == e.src2_tag) && (p.imm == e.imm);
    endfunction

    always_comb begin
        fu_rdy = {br_ready_i, load_ready_i, mul_ready_i, alu_ready_i};
        req[FU_ALU]    = alu_req_o;
        req[FU_MUL]    = mul_req_o;
        req[FU_LOAD]   = load_req_o;
        req[FU_BRANCH] = br_req_o;
        for (int f = 0; f < FU_NUM; f++) begin
            req_vld[f] = req[f].valid;
        end
    end

    assign any_fail = fail_quiet | fail_ready | fail_fast;

    // ============================================================
    // tracking
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            live_cnt  <= 0;
            seen_disp <= 1'b0;
            arm1      <= 1'b0;
            arm2      <= 1'b0;
        end else begin
            live_cnt  <= live_cnt + (dispatch_valid_i && !rs_full_o) - $countones(req_vld);
            seen_disp <= seen_disp | dispatch_valid_i;
            // both sources ready and nothing else in flight
            arm1      <= dispatch_valid_i && !rs_full_o && (live_cnt == 0) &&
                         dispatch_entry_i.src1_rdy && dispatch_entry_i.src2_rdy;
            arm2      <= arm1 && fu_rdy[ent1.fu_type];  // unit took the grant
        end
    end

    always_ff @(posedge clk) begin
        ent1 <= dispatch_entry_i;
        ent2 <= ent1;
    end

    // ============================================================
    // checks and cover points
    // ============================================================
    a_reset_quiet: assert property (@(posedge clk) disable iff (reset)
        !seen_disp |-> (req_vld == '0) && !rs_full_o)
        else begin fail_quiet = 1'b1; $error("request or full before first dispatch"); end

    a_ready_before_valid: assert property (@(posedge clk) disable iff (reset)
        (req_vld & ~$past(fu_rdy)) == '0)
        else begin fail_ready = 1'b1; $error("request to a unit that was not ready"); end

    a_fast_issue: assert property (@(posedge clk) disable iff (reset)
        arm2 |-> packet_ok(req[ent2.fu_type], ent2))
        else begin fail_fast = 1'b1; $error("ready op missed its two-cycle issue slot"); end

    c_dual_issue: cover property (@(posedge clk) disable iff (reset) $countones(req_vld) >= 2);
    c_full:       cover property (@(posedge clk) disable iff (reset) $rose(rs_full_o));

endmodule

// File: tests/issue_tb.sv
`timescale 1ns/1ps

module issue_tb import ooo_pkg::*; ();

    localparam int N_RAND       = 200;
    localparam int N_DIR        = 10;                        // fast + wakeup + fill
    localparam int WATCHDOG_NS  = (N_RAND + N_DIR) * 40 * 20;
    localparam int DRAIN_CYCLES = 100;                       // per drain, then give up

    logic                            clk = 1'b0;
    logic                            reset;
    logic                            dispatch_valid_i;
    rs_entry_t                       dispatch_entry_i;
    logic                            rs_full_o;
    logic [CDB_WIDTH-1:0]            cdb_valid_i;
    logic [CDB_WIDTH-1:0][TAG_W-1:0] cdb_tag_i;
    logic                            alu_ready_i;
    logic                            mul_ready_i;
    logic                            load_ready_i;
    logic                            br_ready_i;
    issue_packet_t                   alu_req_o;
    issue_packet_t                   mul_req_o;
    issue_packet_t                   load_req_o;
    issue_packet_t                   br_req_o;

    logic [31:0]          lcg_state = 32'h4650;
    logic                 rand_mode = 1'b0;  // cdb and fu ready from the lcg
    logic [ROB_W-1:0]     next_rob = '0;
    rs_entry_t            exp_q [ROB_DEPTH];   // expected fields, src rdy = model wakeup
    logic [ROB_DEPTH-1:0] live = '0;
    int                   n_live = 0;

    issue_top i_dut (.*);

    bind issue_top issue_asserts i_chk (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rs_entry_t make_op(input fu_type_e fu, input logic r1, input logic r2);
        rs_entry_t   e;
        logic [31:0] r;
        r          = next_rand();
        e          = '0;
        e.valid    = 1'b1;
        e.fu_type  = fu;
        case (fu)  // legal opcode for the unit
            FU_ALU:  e.opcode = opcode_e'(3'(r[1:0]));
            FU_MUL:  e.opcode = r[0] ? OP_MULH : OP_MUL;
            FU_LOAD: e.opcode = OP_LOAD;
            default: e.opcode = OP_BEQ;
        endcase
        e.dest_tag = r[7:2];
        e.src1_tag = r[13:8];
        e.src2_tag = r[19:14];
        e.src1_rdy = r1;
        e.src2_rdy = r2;
        e.imm      = next_rand();
        return e;
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // broadcast one still-waiting tag, scan starts at a random rob idx
    task automatic pick_wakeup(input int lane, input logic [ROB_W-1:0] start);
        logic [ROB_W-1:0] idx;
        for (int k = 0; k < ROB_DEPTH; k++) begin
            idx = start + ROB_W'(k);
            if (live[idx] && !(exp_q[idx].src1_rdy && exp_q[idx].src2_rdy)) begin
                cdb_valid_i[lane] = 1'b1;
                cdb_tag_i[lane]   = exp_q[idx].src1_rdy ? exp_q[idx].src2_tag
                                                        : exp_q[idx].src1_tag;
                return;
            end
        end
    endtask

    // next drive point, 1 ns after the edge
    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        #1;
        dispatch_valid_i = 1'b0;
        cdb_valid_i      = '0;
        if (rand_mode) begin
            r = next_rand();
            {alu_ready_i, mul_ready_i, load_ready_i, br_ready_i} = r[3:0] | r[7:4];  // ~75%
            for (int c = 0; c < CDB_WIDTH; c++) begin
                r = next_rand();
                if (r[1:0] != 2'd0) pick_wakeup(c, r[12:8]);
            end
        end
    endtask

    task automatic send_op(input rs_entry_t e);
        e.rob_idx = next_rob;
        while (rs_full_o || live[next_rob]) tick();  // no strobe while full
        dispatch_valid_i = 1'b1;
        dispatch_entry_i = e;
        next_rob++;
        tick();
    endtask

    // wait for the station to empty, a stuck op stays in live
    task automatic drain();
        int waited;
        waited = 0;
        while (n_live != 0 && waited < DRAIN_CYCLES) begin
            tick();
            waited++;
        end
    endtask

    // ============================================================
    // scoreboard, sampled mid-cycle
    // ============================================================
    task automatic check_req(input issue_packet_t p, input fu_type_e fu);
        rs_entry_t e;
        if (p.valid) begin
            e = exp_q[p.rob_idx];
            assert (live[p.rob_idx])
                else abort($sformatf("[FAIL] t=%0t: rob %0d issued but not outstanding",
                                     $time, p.rob_idx));
            assert (p.fu_type == fu && e.fu_type == fu && p.opcode == e.opcode &&
                    p.dest_tag == e.dest_tag && p.src1_tag == e.src1_tag &&
                    p.src2_tag == e.src2_tag && p.imm == e.imm)
                else abort($sformatf("[FAIL] t=%0t: rob %0d packet fields differ from dispatch",
                                     $time, p.rob_idx));
            assert (e.src1_rdy && e.src2_rdy)
                else abort($sformatf("[FAIL] t=%0t: rob %0d issued before its tag broadcast",
                                     $time, p.rob_idx));
            live[p.rob_idx] = 1'b0;
            n_live--;
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (i_dut.i_chk.any_fail) begin
                abort($sformatf("[FAIL] t=%0t: assertion in issue_asserts failed", $time));
            end
            check_req(alu_req_o, FU_ALU);
            check_req(mul_req_o, FU_MUL);
            check_req(load_req_o, FU_LOAD);
            check_req(br_req_o, FU_BRANCH);
            if (dispatch_valid_i && !rs_full_o) begin
                exp_q[dispatch_entry_i.rob_idx] = dispatch_entry_i;
                live[dispatch_entry_i.rob_idx]  = 1'b1;
                n_live++;
            end
            // same-cycle broadcast also wakes the op being dispatched
            for (int c = 0; c < CDB_WIDTH; c++) begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    if (cdb_valid_i[c] && live[i] && exp_q[i].src1_tag == cdb_tag_i[c])
                        exp_q[i].src1_rdy = 1'b1;
                    if (cdb_valid_i[c] && live[i] && exp_q[i].src2_tag == cdb_tag_i[c])
                        exp_q[i].src2_rdy = 1'b1;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort($sformatf("timeout: run did not finish within %0d ns", WATCHDOG_NS));
    end

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        rs_entry_t   e;
        logic [31:0] r;
        reset            = 1'b1;
        dispatch_valid_i = 1'b0;
        dispatch_entry_i = '0;
        cdb_valid_i      = '0;
        cdb_tag_i        = '0;
        {alu_ready_i, mul_ready_i, load_ready_i, br_ready_i} = 4'h0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // lone ready op, two-cycle path
        {alu_ready_i, mul_ready_i, load_ready_i, br_ready_i} = 4'hf;
        send_op(make_op(FU_MUL, 1'b1, 1'b1));
        drain();

        // src1 waits for its broadcast
        e = make_op(FU_LOAD, 1'b0, 1'b1);
        send_op(e);
        repeat (6) tick();
        cdb_valid_i[0] = 1'b1;
        cdb_tag_i[0]   = e.src1_tag;
        tick();
        drain();

        // all units stalled, fill the station, then release
        {alu_ready_i, mul_ready_i, load_ready_i, br_ready_i} = 4'h0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            send_op(make_op(fu_type_e'(2'(i)), 1'b1, 1'b1));
        end
        assert (rs_full_o)
            else abort($sformatf("[FAIL] t=%0t: station not full after eight dispatches", $time));
        {alu_ready_i, mul_ready_i, load_ready_i, br_ready_i} = 4'hf;
        drain();

        rand_mode = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            r = next_rand();
            send_op(make_op(fu_type_e'(r[1:0]), r[2], r[3]));
        end
        drain();

        if (i_dut.i_chk.any_fail) begin
            abort($sformatf("[FAIL] t=%0t: assertion in issue_asserts failed", $time));
        end else if (live != '0) begin
            abort($sformatf("[FAIL] t=%0t: %0d ops left outstanding", $time, n_live));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule
